// File: Bender.yml
package:
  name: root_hub

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - root_hub_pkg.sv
      - hub_fifo.sv
      - hub_router.sv
      - decode_controller.sv
      - root_hub.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_leaf_model.sv
      - tb_root_hub.sv

// File: decode_controller.sv
`timescale 1ns/1ps
`include "root_hub_settings.svh"

module decode_controller (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         multi_fpga_run,

    // broadcast stream toward the leaves
    output root_hub_pkg::hub_word_t      tx_data,
    output logic                         tx_valid,
    input  logic                         tx_ready,

    // result stream from the leaves
    input  root_hub_pkg::hub_word_t      rx_data,
    input  logic                         rx_valid,
    output logic                         rx_ready,

    output logic                         result_valid,
    output root_hub_pkg::hub_byte_t      result_leaf,
    output root_hub_pkg::cycles_t        result_cycles,
    output root_hub_pkg::iterations_t    result_iterations,
    output root_hub_pkg::case_count_t    test_case,
    output logic                         done
);

    localparam int PAD_W = `HUB_WORD_WIDTH - 24;

    root_hub_pkg::ctrl_state_t state;
    root_hub_pkg::hub_byte_t   fpga_count;   // results seen this case
    logic                      multi_latched;
    logic                      cases_left;
    logic                      last_result;

    assign cases_left  = (test_case < root_hub_pkg::case_count_t'(`HUB_MAX_COUNT));
    assign last_result = multi_latched ||
                         (fpga_count == root_hub_pkg::hub_byte_t'(`HUB_NUM_LEAVES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= root_hub_pkg::idle;
            test_case     <= '0;
            fpga_count    <= '0;
            multi_latched <= 1'b0;
            result_valid  <= 1'b0;
            done          <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                root_hub_pkg::idle: begin
                    if (tx_ready && cases_left) begin
                        state         <= root_hub_pkg::start_decoding;
                        test_case     <= test_case + 1'b1;
                        multi_latched <= multi_fpga_run;    // held for the whole case
                        fpga_count    <= '0;
                    end
                    if (!cases_left) begin
                        done <= 1'b1;
                    end
                end
                root_hub_pkg::start_decoding: begin
                    if (tx_ready) begin
                        state <= root_hub_pkg::measurement_data;
                    end
                end
                root_hub_pkg::measurement_data: begin
                    if (tx_ready) begin
                        state <= root_hub_pkg::wait_for_result;
                    end
                end
                root_hub_pkg::wait_for_result: begin
                    if (rx_valid) begin
                        fpga_count   <= fpga_count + 1'b1;
                        result_valid <= 1'b1;
                        if (last_result) begin
                            state <= root_hub_pkg::idle;
                        end
                    end
                end
                default: state <= root_hub_pkg::idle;
            endcase
        end
    end

    // result fields, qualified by result_valid
    always_ff @(posedge clk) begin
        if (rx_valid && rx_ready) begin
            result_leaf       <= rx_data[55:48];    // source byte
            result_cycles     <= rx_data[39:24];
            result_iterations <= rx_data[47:40];
        end
    end

    always_comb begin
        tx_data  = '0;
        tx_valid = 1'b0;
        rx_ready = 1'b0;
        case (state)
            root_hub_pkg::start_decoding: begin
                tx_data  = {`HUB_BROADCAST_DEST, `HUB_ROOT_ID, `HUB_MSG_START,
                            {(PAD_W - 1){1'b0}}, multi_latched};
                tx_valid = 1'b1;
            end
            root_hub_pkg::measurement_data: begin
                tx_data  = {`HUB_BROADCAST_DEST, `HUB_ROOT_ID, `HUB_MSG_HEADER,
                            {PAD_W{1'b0}}};
                tx_valid = 1'b1;
            end
            root_hub_pkg::wait_for_result: rx_ready = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: hub_fifo.sv
`timescale 1ns/1ps

module hub_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] input_data,
    input  logic             input_valid,
    output logic             input_ready,
    output logic [WIDTH-1:0] output_data,
    output logic             output_valid,
    input  logic             output_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             push;
    logic             pop;

    assign push = input_valid && input_ready;
    assign pop  = output_valid && output_ready;

    // first word falls through
    assign output_valid = (count != '0);
    assign output_data  = mem[rd_ptr];

    always_comb begin
        case ({push, pop})
            2'b10:   count_next = count + CNT_W'(1);
            2'b01:   count_next = count - CNT_W'(1);
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            input_ready <= 1'b0;    // comes up one cycle after reset
        end else begin
            count       <= count_next;
            input_ready <= (count_next != CNT_W'(DEPTH));
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= input_data;
        end
    end

endmodule

// File: hub_router.sv
`timescale 1ns/1ps
`include "root_hub_settings.svh"

module hub_router (
    input  logic clk,
    input  logic reset,

    // root side, down path in
    input  root_hub_pkg::hub_word_t                         root_in_data,
    input  logic                                            root_in_valid,
    output logic                                            root_in_ready,

    // root side, up path out
    output root_hub_pkg::hub_word_t                         root_out_data,
    output logic                                            root_out_valid,
    input  logic                                            root_out_ready,

    // leaf side, up path in
    input  root_hub_pkg::hub_word_t [`HUB_NUM_LEAVES-1:0]   leaf_in_data,
    input  root_hub_pkg::leaf_mask_t                        leaf_in_valid,
    output root_hub_pkg::leaf_mask_t                        leaf_in_ready,

    // leaf side, down path out
    output root_hub_pkg::hub_word_t [`HUB_NUM_LEAVES-1:0]   leaf_out_data,
    output root_hub_pkg::leaf_mask_t                        leaf_out_valid,
    input  root_hub_pkg::leaf_mask_t                        leaf_out_ready
);

    localparam int N     = `HUB_NUM_LEAVES;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    root_hub_pkg::hub_byte_t  dest;
    root_hub_pkg::leaf_mask_t target;
    root_hub_pkg::leaf_mask_t served;
    root_hub_pkg::leaf_mask_t accepted;
    root_hub_pkg::leaf_mask_t finished;

    logic [IDX_W-1:0] last_grant;
    logic [IDX_W-1:0] grant_idx;
    logic             grant_found;
    int               cand;

    // downstream

    assign dest = root_in_data[`HUB_WORD_WIDTH-1 -: 8];

    always_comb begin
        target = '0;
        if (dest == `HUB_BROADCAST_DEST) begin
            target = '1;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (dest == root_hub_pkg::hub_byte_t'(i)) begin
                    target[i] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            leaf_out_data[i] = root_in_data;
        end
    end

    assign leaf_out_valid = {N{root_in_valid}} & target & ~served;
    assign accepted       = leaf_out_valid & leaf_out_ready;
    assign finished       = served | accepted | ~target;

    // retire once every addressed leaf has the word
    assign root_in_ready = root_in_valid && (&finished);

    always_ff @(posedge clk) begin
        if (reset) begin
            served <= '0;
        end else if (root_in_valid && root_in_ready) begin
            served <= '0;
        end else if (root_in_valid) begin
            served <= served | accepted;
        end
    end

    // upstream, round robin starting after the last grant

    always_comb begin
        grant_found = 1'b0;
        grant_idx   = last_grant;
        cand        = 0;
        for (int off = 1; off <= N; off++) begin
            cand = (int'(last_grant) + off) % N;
            if (!grant_found && leaf_in_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx   = IDX_W'(cand);
            end
        end
    end

    assign root_out_valid = grant_found;
    assign root_out_data  = leaf_in_data[grant_idx];

    always_comb begin
        leaf_in_ready = '0;
        if (grant_found && root_out_ready) begin
            leaf_in_ready[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= IDX_W'(N - 1);    // leaf 0 goes first
        end else if (root_out_valid && root_out_ready) begin
            last_grant <= grant_idx;
        end
    end

endmodule

// File: root_hub.sv
`timescale 1ns/1ps
`include "root_hub_settings.svh"

module root_hub (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            multi_fpga_run,

    output root_hub_pkg::hub_word_t [`HUB_NUM_LEAVES-1:0]   down_tx_data,
    output root_hub_pkg::leaf_mask_t                        down_tx_valid,
    input  root_hub_pkg::leaf_mask_t                        down_tx_ready,

    input  root_hub_pkg::hub_word_t [`HUB_NUM_LEAVES-1:0]   up_rx_data,
    input  root_hub_pkg::leaf_mask_t                        up_rx_valid,
    output root_hub_pkg::leaf_mask_t                        up_rx_ready,

    output logic                                            result_valid,
    output root_hub_pkg::hub_byte_t                         result_leaf,
    output root_hub_pkg::cycles_t                           result_cycles,
    output root_hub_pkg::iterations_t                       result_iterations,
    output root_hub_pkg::case_count_t                       test_case,
    output logic                                            done
);

    // controller to controller_fifo
    root_hub_pkg::hub_word_t ctrl_tx_data;
    logic                    ctrl_tx_valid;
    logic                    ctrl_tx_ready;

    // controller_fifo to router
    root_hub_pkg::hub_word_t root_in_data;
    logic                    root_in_valid;
    logic                    root_in_ready;

    // router to parent_fifo
    root_hub_pkg::hub_word_t root_out_data;
    logic                    root_out_valid;
    logic                    root_out_ready;

    // parent_fifo to controller
    root_hub_pkg::hub_word_t ctrl_rx_data;
    logic                    ctrl_rx_valid;
    logic                    ctrl_rx_ready;

    decode_controller i_decode_controller (
        .clk               (clk),
        .reset             (reset),
        .multi_fpga_run    (multi_fpga_run),
        .tx_data           (ctrl_tx_data),
        .tx_valid          (ctrl_tx_valid),
        .tx_ready          (ctrl_tx_ready),
        .rx_data           (ctrl_rx_data),
        .rx_valid          (ctrl_rx_valid),
        .rx_ready          (ctrl_rx_ready),
        .result_valid      (result_valid),
        .result_leaf       (result_leaf),
        .result_cycles     (result_cycles),
        .result_iterations (result_iterations),
        .test_case         (test_case),
        .done              (done)
    );

    hub_fifo #(
        .WIDTH (`HUB_WORD_WIDTH),
        .DEPTH (`HUB_FIFO_DEPTH)
    ) controller_fifo (
        .clk          (clk),
        .reset        (reset),
        .input_data   (ctrl_tx_data),
        .input_valid  (ctrl_tx_valid),
        .input_ready  (ctrl_tx_ready),
        .output_data  (root_in_data),
        .output_valid (root_in_valid),
        .output_ready (root_in_ready)
    );

    hub_fifo #(
        .WIDTH (`HUB_WORD_WIDTH),
        .DEPTH (`HUB_FIFO_DEPTH)
    ) parent_fifo (
        .clk          (clk),
        .reset        (reset),
        .input_data   (root_out_data),
        .input_valid  (root_out_valid),
        .input_ready  (root_out_ready),
        .output_data  (ctrl_rx_data),
        .output_valid (ctrl_rx_valid),
        .output_ready (ctrl_rx_ready)
    );

    hub_router i_hub_router (
        .clk            (clk),
        .reset          (reset),
        .root_in_data   (root_in_data),
        .root_in_valid  (root_in_valid),
        .root_in_ready  (root_in_ready),
        .root_out_data  (root_out_data),
        .root_out_valid (root_out_valid),
        .root_out_ready (root_out_ready),
        .leaf_in_data   (up_rx_data),
        .leaf_in_valid  (up_rx_valid),
        .leaf_in_ready  (up_rx_ready),
        .leaf_out_data  (down_tx_data),
        .leaf_out_valid (down_tx_valid),
        .leaf_out_ready (down_tx_ready)
    );

endmodule

// File: root_hub_pkg.sv
`include "root_hub_settings.svh"

package root_hub_pkg;

    // one channel word, byte 7 dest, byte 6 src, byte 5 type
    typedef logic [`HUB_WORD_WIDTH-1:0] hub_word_t;

    typedef logic [7:0] hub_byte_t;     // one header field

    typedef logic [15:0] cycles_t;      // result bits 39:24
    typedef logic [7:0] iterations_t;   // result bits 47:40

    typedef logic [31:0] case_count_t;

    // one bit per leaf channel
    typedef logic [`HUB_NUM_LEAVES-1:0] leaf_mask_t;

    // decode controller states
    typedef enum logic [1:0] {
        idle,
        start_decoding,
        measurement_data,
        wait_for_result
    } ctrl_state_t;

endpackage

// File: root_hub_settings.svh
`ifndef ROOT_HUB_SETTINGS_SVH
`define ROOT_HUB_SETTINGS_SVH

// channel and array sizing
`define HUB_NUM_LEAVES 3
`define HUB_WORD_WIDTH 64
`define HUB_FIFO_DEPTH 16

// test cases per run
`define HUB_MAX_COUNT 6

// header field values
`define HUB_BROADCAST_DEST 8'hff
`define HUB_ROOT_ID 8'hff

// message type codes, byte 5 of a word
`define HUB_MSG_START 8'h01
`define HUB_MSG_HEADER 8'h02
`define HUB_MSG_RESULT 8'h03

`endif

// File: sim.f
+incdir+.
root_hub_pkg.sv
hub_fifo.sv
hub_router.sv
decode_controller.sv
root_hub.sv
tb_leaf_model.sv
tb_root_hub.sv

// File: tb_leaf_model.sv
`timescale 1ns/1ps
`include "root_hub_settings.svh"

module tb_leaf_model #(
    parameter int          LEAF_INDEX = 0,
    parameter int unsigned SEED       = 52
) (
    input  logic                    clk,
    input  logic                    reset,
    input  root_hub_pkg::hub_word_t down_data,
    input  logic                    down_valid,
    output logic                    down_ready,
    output root_hub_pkg::hub_word_t up_data,
    output logic                    up_valid,
    input  logic                    up_ready,
    output int                      msg_count
);

    int unsigned             rng;
    int                      case_num;      // starts seen since reset
    int                      delay;
    logic                    multi_flag;
    logic                    reply_pending;
    logic                    got_reset;
    logic                    got_down;
    logic                    got_up;
    root_hub_pkg::hub_word_t got_word;

    function automatic int unsigned lcg_step(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        rng        = SEED;
        down_ready = 1'b0;
        up_valid   = 1'b0;
        up_data    = '0;
        msg_count  = 0;
    end

    // handshakes seen on the rising edge, handled at the falling edge
    always @(posedge clk) begin
        got_reset <= reset;
        got_down  <= down_valid && down_ready;
        got_up    <= up_valid && up_ready;
        got_word  <= down_data;
    end

    always @(negedge clk) begin
        int unsigned roll;
        rng  = lcg_step(rng);
        roll = rng >> 16;
        if (got_reset) begin
            down_ready    <= 1'b0;
            up_valid      <= 1'b0;
            msg_count     <= 0;
            case_num      = 0;
            delay         = 0;
            multi_flag    = 1'b0;
            reply_pending = 1'b0;
        end else begin
            down_ready <= (roll % 4) != 0;    // roughly one stall in four
            if (got_up) begin
                up_valid <= 1'b0;
            end
            if (got_down) begin
                msg_count <= msg_count + 1;
                if (got_word[47:40] == `HUB_MSG_START) begin
                    case_num   = case_num + 1;
                    multi_flag = got_word[0];
                end else if (got_word[47:40] == `HUB_MSG_HEADER) begin
                    // leaf 0 answers for the whole array in a multi-board run
                    reply_pending = !multi_flag || (LEAF_INDEX == 0);
                    delay         = int'((roll >> 2) % 8);
                end
            end
            if (reply_pending) begin
                if (delay == 0) begin
                    up_valid      <= 1'b1;
                    // iteration count sits in byte 5
                    up_data       <= {`HUB_ROOT_ID, 8'(LEAF_INDEX), 8'(case_num + LEAF_INDEX),
                                      16'(100 * case_num + 10 * LEAF_INDEX), 24'h0};
                    reply_pending = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

endmodule

// File: tb_root_hub.sv
`timescale 1ns/1ps
`include "root_hub_settings.svh"

module tb_root_hub;

    localparam int N              = `HUB_NUM_LEAVES;
    localparam int MAX_CASES      = `HUB_MAX_COUNT;
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int SEED           = 52;

    logic                              clk;
    logic                              reset;
    logic                              multi_fpga_run;
    root_hub_pkg::hub_word_t [N-1:0]   down_tx_data;
    root_hub_pkg::leaf_mask_t          down_tx_valid;
    wire root_hub_pkg::leaf_mask_t     down_tx_ready;
    wire root_hub_pkg::hub_word_t [N-1:0] up_rx_data;
    wire root_hub_pkg::leaf_mask_t     up_rx_valid;
    root_hub_pkg::leaf_mask_t          up_rx_ready;
    logic                              result_valid;
    root_hub_pkg::hub_byte_t           result_leaf;
    root_hub_pkg::cycles_t             result_cycles;
    root_hub_pkg::iterations_t         result_iterations;
    root_hub_pkg::case_count_t         test_case;
    logic                              done;

    int       leaf_msgs [N];       // as counted by each leaf model
    int       leaf_starts [N];
    logic [N-1:0] expect_header;
    logic [N-1:0] case_mask;       // leaves reported in the current case
    int       result_total;

    root_hub i_root_hub (.*);

    for (genvar i = 0; i < N; i++) begin : g_leaf
        tb_leaf_model #(
            .LEAF_INDEX (i),
            .SEED       (SEED + i)
        ) i_leaf (
            .clk        (clk),
            .reset      (reset),
            .down_data  (down_tx_data[i]),
            .down_valid (down_tx_valid[i]),
            .down_ready (down_tx_ready[i]),
            .up_data    (up_rx_data[i]),
            .up_valid   (up_rx_valid[i]),
            .up_ready   (up_rx_ready[i]),
            .msg_count  (leaf_msgs[i])
        );
    end

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_idle_outputs(input string when);
        assert (down_tx_valid == '0 && up_rx_ready == '0 && !result_valid && !done)
            else report_failure($sformatf(
                "mismatch at %0t: %s valid %b up_ready %b result_valid %b done %b",
                $time, when, down_tx_valid, up_rx_ready, result_valid, done));
    endtask

    // scoreboard, sampled on the rising edge
    always @(posedge clk) begin
        root_hub_pkg::hub_word_t word;
        int per_case;
        int tc;
        per_case = multi_fpga_run ? 1 : N;
        tc       = int'(test_case);
        if (reset) begin
            result_total  = 0;
            case_mask     = '0;
            expect_header = '0;
            for (int i = 0; i < N; i++) begin
                leaf_starts[i] = 0;
            end
        end else begin
            if (result_valid) begin
                if (result_total == (tc - 1) * per_case) begin
                    case_mask = '0;
                end
                assert (result_total < tc * per_case)
                    else report_failure($sformatf(
                        "mismatch at %0t: extra result from leaf %0d in case %0d",
                        $time, result_leaf, tc));
                assert (result_leaf < N && !case_mask[result_leaf] &&
                        !(multi_fpga_run && result_leaf != 0))
                    else report_failure($sformatf(
                        "mismatch at %0t: unexpected result from leaf %0d in case %0d",
                        $time, result_leaf, tc));
                assert (result_cycles == 16'(100 * tc + 10 * result_leaf) &&
                        result_iterations == 8'(tc + result_leaf))
                    else report_failure($sformatf(
                        "mismatch at %0t: case %0d leaf %0d cycles %0d iterations %0d",
                        $time, tc, result_leaf, result_cycles, result_iterations));
                case_mask[result_leaf] = 1'b1;
                result_total++;
            end
            for (int i = 0; i < N; i++) begin
                if (down_tx_valid[i] && down_tx_ready[i]) begin
                    word = down_tx_data[i];
                    assert (word[63:56] == `HUB_BROADCAST_DEST && word[55:48] == `HUB_ROOT_ID)
                        else report_failure($sformatf(
                            "mismatch at %0t: leaf %0d got word %h",
                            $time, i, word));
                    if (!expect_header[i]) begin
                        assert (word[47:40] == `HUB_MSG_START && word[0] == multi_fpga_run)
                            else report_failure($sformatf(
                                "mismatch at %0t: leaf %0d expected start, got %h",
                                $time, i, word));
                        // previous case must be fully reported first
                        assert (result_total == leaf_starts[i] * per_case)
                            else report_failure($sformatf(
                                "mismatch at %0t: leaf %0d start with %0d results seen",
                                $time, i, result_total));
                        leaf_starts[i]++;
                    end else begin
                        assert (word[47:40] == `HUB_MSG_HEADER)
                            else report_failure($sformatf(
                                "mismatch at %0t: leaf %0d expected header, got %h",
                                $time, i, word));
                    end
                    expect_header[i] = !expect_header[i];
                end
            end
        end
    end

    task automatic run_phase(input logic multi);
        int waited;
        int per_case;
        per_case = multi ? 1 : N;
        @(negedge clk);
        reset          = 1'b1;
        multi_fpga_run = multi;
        repeat (8) begin
            @(posedge clk);
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        reset = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_idle_outputs("after reset");
        waited = 0;
        while (!done) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_failure($sformatf(
                    "timeout: done never rose with multi_fpga_run %0b", multi));
            end
        end
        assert (test_case == MAX_CASES && result_total == MAX_CASES * per_case)
            else report_failure($sformatf(
                "mismatch at %0t: test_case %0d results %0d at done",
                $time, test_case, result_total));
        for (int i = 0; i < N; i++) begin
            assert (leaf_msgs[i] == 2 * int'(test_case) && leaf_starts[i] == MAX_CASES)
                else report_failure($sformatf(
                    "mismatch at %0t: leaf %0d received %0d messages",
                    $time, i, leaf_msgs[i]));
        end
        repeat (50) begin
            @(negedge clk);
            assert (down_tx_valid == '0 && done)
                else report_failure($sformatf(
                    "mismatch at %0t: traffic after done, valid %b",
                    $time, down_tx_valid));
        end
    endtask

    initial begin
        reset          = 1'b1;
        multi_fpga_run = 1'b0;
        run_phase(1'b0);
        run_phase(1'b1);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
